/* design/nocPkg.sv */
package nocPkg;

  localparam int NUM_PORTS = 5;
  localparam int PORT_W = 3;

  typedef logic [PORT_W-1:0] portIdxT;

  // rotation order of the arbiter follows these indices
  localparam portIdxT PORT_L = 3'd0;
  localparam portIdxT PORT_N = 3'd1;
  localparam portIdxT PORT_E = 3'd2;
  localparam portIdxT PORT_W_IDX = 3'd3;
  localparam portIdxT PORT_S = 3'd4;

  localparam int QUEUE_DEPTH = 4; // also the starting credit of each upstream sender
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

  localparam int DOWN_CREDITS = 3;
  localparam int CREDIT_W = $clog2(DOWN_CREDITS + 1);

  typedef logic [NUM_PORTS-1:0] portVecT;

  // bit 0 is idle, bit i+1 means port i holds the output
  typedef logic [NUM_PORTS:0] arbStateT;
  localparam arbStateT ARB_IDLE = 6'b000001;

  typedef enum logic [2:0]
  {
    FLIT_HEAD = 3'b001,
    FLIT_BODY = 3'b010
  } flitKindT;

  typedef struct packed
  {
    logic [11:0] pktLength; // flits in the packet, head included
    logic [3:0] route;
  } headFieldsT;

  typedef union packed
  {
    headFieldsT head;
    logic [15:0] body;
  } flitPayloadT;

  typedef struct packed
  {
    flitKindT kind;
    flitPayloadT payload;
  } flitT;

endpackage

/* design/flitQueue.sv */
`timescale 1ns/1ns

module flitQueue
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  flitT wrFlit,
  input  logic wrValid,
  input  logic pop,
  output flitT headFlit,
  output logic notEmpty,
  output logic creditReturn
);

  flitT mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] rdPtr;
  logic [QPTR_W-1:0] wrPtr;
  logic [QCNT_W-1:0] count;
  logic full;
  logic doWrite;
  logic doPop;

  assign full = (count == QCNT_W'(QUEUE_DEPTH));
  assign notEmpty = (count != '0);
  assign doWrite = wrValid && !full; // the sender's credit keeps this from ever blocking
  assign doPop = pop && notEmpty;

  assign headFlit = mem[rdPtr]; // oldest flit is always on view

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      mem[wrPtr] <= wrFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
      creditReturn <= 1'b0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= (wrPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= (rdPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doWrite, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      creditReturn <= doPop; // one credit back upstream per freed slot
    end
  end

endmodule

/* design/portArbiter.sv */
`timescale 1ns/1ns

module portArbiter
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portVecT notEmpty,
  input  flitT    headFlit [NUM_PORTS],
  input  logic    sent,
  output portVecT grant
);

  arbStateT state;
  arbStateT nextState;
  portIdxT lastPort;
  portIdxT pickIdx;
  logic anyReq;
  logic lastFlit;
  logic [11:0] holdCount;
  headFieldsT pickHead;

  // first requester after the last holder, wrapping around the five ports
  function automatic portIdxT pickNext(portVecT req, portIdxT last);
    portIdxT pick;
    logic found;
    int idx;
    pick = last;
    found = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++)
    begin
      idx = (int'(last) + k) % NUM_PORTS;
      if (!found && req[idx])
      begin
        pick = portIdxT'(idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign anyReq = |notEmpty;
  assign pickIdx = pickNext(notEmpty, lastPort);
  assign pickHead = headFlit[pickIdx].payload.head; // only ever a head flit while idle
  assign lastFlit = sent && (holdCount <= 12'd1);

  assign grant = state[NUM_PORTS:1];

  always_comb
  begin
    nextState = state;
    if (state == ARB_IDLE)
    begin
      if (anyReq)
      begin
        nextState = arbStateT'(2) << pickIdx;
      end
    end
    else if (!$onehot(state))
    begin
      nextState = ARB_IDLE; // recover from a corrupted state word
    end
    else if (lastFlit)
    begin
      nextState = ARB_IDLE; // the output is free for one cycle between packets
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ARB_IDLE;
      holdCount <= '0;
      lastPort <= PORT_S; // so that L wins first after reset
    end
    else
    begin
      state <= nextState;
      if (state == ARB_IDLE)
      begin
        if (anyReq)
        begin
          holdCount <= pickHead.pktLength;
          lastPort <= pickIdx;
        end
      end
      else if (sent && (holdCount > 12'd1))
      begin
        holdCount <= holdCount - 12'd1;
      end
    end
  end

endmodule

/* design/outputStage.sv */
`timescale 1ns/1ns

module outputStage
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portVecT grant,
  input  portVecT notEmpty,
  input  flitT    headFlit [NUM_PORTS],
  input  logic    creditIn,
  output portVecT popVec,
  output logic    sent,
  output flitT    outFlit,
  output logic    outValid
);

  logic [CREDIT_W-1:0] creditCount;
  flitT selFlit;
  logic selReady;
  logic canSend;

  always_comb
  begin
    selFlit = headFlit[0];
    selReady = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        selFlit = headFlit[i];
        selReady = notEmpty[i];
      end
    end
  end

  // a flit moves only with a granted, non-empty queue and a free downstream slot
  assign canSend = selReady && (creditCount != '0);
  assign popVec = canSend ? grant : '0;
  assign sent = canSend;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      creditCount <= CREDIT_W'(DOWN_CREDITS);
    end
    else
    begin
      case ({canSend, creditIn})
        2'b10: creditCount <= creditCount - CREDIT_W'(1);
        2'b01: creditCount <= creditCount + CREDIT_W'(1);
        default: creditCount <= creditCount; // both or neither leave it unchanged
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= canSend;
    end
  end

  always_ff @(posedge clk)
  begin
    if (canSend)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

/* design/routerOutPort.sv */
`timescale 1ns/1ns

module routerOutPort
  import nocPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitT    inFlit [NUM_PORTS],
  input  portVecT inValid,
  output portVecT creditReturn,
  output flitT    outFlit,
  output logic    outValid,
  input  logic    creditIn
);

  flitT headFlit [NUM_PORTS];
  portVecT notEmpty;
  portVecT popVec;
  portVecT grant;
  logic sent;

  // one input queue per port, in the order L, N, E, W, S
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gQueue
    flitQueue queue0
    (
      .clk          (clk),
      .rst          (rst),
      .wrFlit       (inFlit[p]),
      .wrValid      (inValid[p]),
      .pop          (popVec[p]),
      .headFlit     (headFlit[p]),
      .notEmpty     (notEmpty[p]),
      .creditReturn (creditReturn[p])
    );
  end

  portArbiter arb0
  (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .sent     (sent),
    .grant    (grant)
  );

  outputStage out0
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .creditIn (creditIn),
    .popVec   (popVec),
    .sent     (sent),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

/* bench/routerOutPort_asserts.sv */
`timescale 1ns/1ns

module routerOutPort_asserts
  import nocPkg::*;
(
  input logic                clk,
  input logic                rst,
  input portVecT             grant,
  input logic                outValid,
  input logic                creditIn,
  input logic                sent,
  input logic [CREDIT_W-1:0] creditCount,
  input portVecT             inValid,
  input portVecT             queueFull
);

  int unanswered; // flits seen on the output that downstream has not given back yet

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      unanswered <= 0;
    end
    else
    begin
      unanswered <= unanswered + int'(outValid) - int'(creditIn);
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant %b names more than one port", grant);

  // every flit on the output holds one downstream credit until it is returned
  creditTracksOutput: assert property (@(posedge clk) disable iff (rst)
    int'(creditCount) == DOWN_CREDITS - unanswered - int'(outValid))
    else $error("downstream credit count %0d does not match %0d unanswered flits",
      creditCount, unanswered);

  // a returned credit with no flit leaving must still find room below the reset value
  creditBound: assert property (@(posedge clk) disable iff (rst)
    creditIn && !sent |-> creditCount != CREDIT_W'(DOWN_CREDITS))
    else $error("credit returned while the downstream count is already %0d", creditCount);

  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
    !(|(inValid & queueFull)))
    else $error("queue written while full, inValid %b full %b", inValid, queueFull);

endmodule

bind routerOutPort routerOutPort_asserts asserts0
(
  .clk         (clk),
  .rst         (rst),
  .grant       (grant),
  .outValid    (outValid),
  .creditIn    (creditIn),
  .sent        (sent),
  .creditCount (out0.creditCount),
  .inValid     (inValid),
  .queueFull   ({gQueue[4].queue0.full, gQueue[3].queue0.full, gQueue[2].queue0.full,
                 gQueue[1].queue0.full, gQueue[0].queue0.full})
);

/* bench/routerOutPortTb.sv */
`timescale 1ns/1ns

module routerOutPortTb
  import nocPkg::*;
();

  localparam int PKTS_PER_PORT = 12;
  localparam int TOTAL_PKTS = NUM_PORTS * PKTS_PER_PORT;
  localparam int MAX_LEN = 6;
  localparam int CYCLE_LIMIT = TOTAL_PKTS * MAX_LEN * 8 + 200;
  localparam int RR_HEADS = 25; // five full rounds while every source is saturated
  localparam int HOLD_AT = 35; // head count at which downstream stops returning credits
  localparam int HOLD_CYCLES = 30;

  logic clk;
  logic rst = 1'b1;
  flitT inFlit [NUM_PORTS] = '{default: '0};
  portVecT inValid = '0;
  portVecT creditReturn;
  flitT outFlit;
  logic outValid;
  logic creditIn = 1'b0;

  integer seed = 38374;
  int cycle = 0;
  logic made = 1'b0;
  logic withhold = 1'b0;
  int srcCredit [NUM_PORTS];
  flitT sendQ [NUM_PORTS][$];
  flitT expQ [NUM_PORTS][$];
  int creditDue [$];
  int outstanding;
  int headsSeen;
  int flitsSeen;
  int remaining;
  portIdxT curPort;

  routerOutPort dut0
  (
    .clk          (clk),
    .rst          (rst),
    .inFlit       (inFlit),
    .inValid      (inValid),
    .creditReturn (creditReturn),
    .outFlit      (outFlit),
    .outValid     (outValid),
    .creditIn     (creditIn)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abortRun();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkFlit(string name, flitT actual, flitT expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abortRun();
    end
  endtask

  task automatic checkPort(string name, portIdxT actual, portIdxT expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      abortRun();
    end
  endtask

  task automatic checkCredit(string name, portVecT actual, portVecT expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abortRun();
    end
  endtask

  // every packet goes into the send queue and the expected queue of its port
  task automatic makePackets();
    flitT f;
    int len;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      for (int k = 0; k < PKTS_PER_PORT; k++)
      begin
        len = int'($unsigned($random(seed)) % MAX_LEN) + 1;
        f.kind = FLIT_HEAD;
        f.payload.head.pktLength = 12'(len);
        f.payload.head.route = 4'(p); // the route field tags the source port
        sendQ[p].push_back(f);
        expQ[p].push_back(f);
        for (int b = 1; b < len; b++)
        begin
          f.kind = FLIT_BODY;
          f.payload.body = 16'($random(seed));
          sendQ[p].push_back(f);
          expQ[p].push_back(f);
        end
      end
    end
  endtask

  always @(posedge clk)
  begin
    flitT got;
    flitT want;
    portIdxT src;
    logic enable;
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("timed out after %0d cycles with %0d of %0d packets seen", cycle, headsSeen,
        TOTAL_PKTS);
      abortRun();
    end
    if (rst)
    begin
      inValid <= '0;
      creditIn <= 1'b0;
      outstanding = 0;
      headsSeen = 0;
      flitsSeen = 0;
      remaining = 0;
      curPort = PORT_S; // so the first head is expected from L
      creditDue.delete();
      for (int p = 0; p < NUM_PORTS; p++)
        srcCredit[p] = QUEUE_DEPTH;
      if (!made)
      begin
        makePackets();
        made = 1'b1;
      end
    end
    else
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (creditReturn[p])
        begin
          srcCredit[p] = srcCredit[p] + 1;
          if (srcCredit[p] > QUEUE_DEPTH)
          begin
            $display("port %0d got a credit back beyond its queue depth at %0t ns", p, $time);
            abortRun();
          end
        end
        enable = (headsSeen < RR_HEADS) || ($random(seed) % 4 != 0);
        if (srcCredit[p] > 0 && enable && sendQ[p].size() > 0)
        begin
          inFlit[p] <= sendQ[p].pop_front();
          inValid[p] <= 1'b1;
          srcCredit[p] = srcCredit[p] - 1;
        end
        else
          inValid[p] <= 1'b0;
      end
      if (outValid)
      begin
        got = outFlit;
        flitsSeen++;
        outstanding++;
        if (outstanding > DOWN_CREDITS)
        begin
          $display("%0d flits unanswered downstream at %0t ns, more than the credits", outstanding,
            $time);
          abortRun();
        end
        creditDue.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
        if (got.kind == FLIT_HEAD)
        begin
          if (got.payload.head.route >= NUM_PORTS || remaining != 0)
          begin
            $display("head flit %h arrived out of place at %0t ns", got, $time);
            abortRun();
          end
          src = portIdxT'(got.payload.head.route);
          if (headsSeen < RR_HEADS)
            checkPort("head port", src, portIdxT'((int'(curPort) + 1) % NUM_PORTS));
          curPort = src;
          remaining = int'(got.payload.head.pktLength) - 1;
          headsSeen++;
        end
        else if (got.kind == FLIT_BODY && remaining > 0)
          remaining--;
        else
        begin
          $display("flit %h arrived with no packet open at %0t ns", got, $time);
          abortRun();
        end
        if (expQ[curPort].size() == 0)
        begin
          $display("port %0d delivered more flits than it was given", curPort);
          abortRun();
        end
        want = expQ[curPort].pop_front();
        checkFlit("outFlit", got, want);
      end
      creditIn <= 1'b0;
      if (!withhold && creditDue.size() > 0 && creditDue[0] <= cycle)
      begin
        void'(creditDue.pop_front());
        creditIn <= 1'b1;
        outstanding--;
      end
    end
  end

  initial
  begin
    int stallFlits;
    int waited;
    portVecT creditFull;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (headsSeen < HOLD_AT)
      @(negedge clk);
    withhold = 1'b1; // downstream keeps its slots for a while
    repeat (HOLD_CYCLES) @(negedge clk);
    if (outstanding != DOWN_CREDITS)
    begin
      $display("output did not stop after %0d flits during the credit stall, %0d unanswered",
        DOWN_CREDITS, outstanding);
      abortRun();
    end
    stallFlits = flitsSeen;
    withhold = 1'b0;
    waited = 0;
    while (flitsSeen == stallFlits && waited < 20)
    begin
      @(negedge clk);
      waited++;
    end
    if (flitsSeen == stallFlits)
    begin
      $display("output did not resume after the downstream credits came back");
      abortRun();
    end
    while (headsSeen < TOTAL_PKTS || remaining != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (expQ[p].size() != 0 || sendQ[p].size() != 0)
      begin
        $display("port %0d still has %0d flits that never arrived", p, expQ[p].size());
        abortRun();
      end
      creditFull[p] = (srcCredit[p] == QUEUE_DEPTH);
    end
    checkCredit("source credits restored", creditFull, '1);
    $display("Test passed");
    $finish;
  end

endmodule

/* tb.f */
design/nocPkg.sv
design/flitQueue.sv
design/portArbiter.sv
design/outputStage.sv
design/routerOutPort.sv
bench/routerOutPort_asserts.sv
bench/routerOutPortTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = routerOutPortTb
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
